// ==== all.f ====
+incdir+source
source/csr_isa_pkg.sv
source/csr_port_pkg.sv
source/csr_request_ctrl.sv
source/csr_counter.sv
source/csr_trap_regs.sv
source/csr_read_mux.sv
source/csr_unit.sv
dv/csr_unit_tb.sv

// ==== dv/csr_unit_tb.sv ====
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_unit_tb;
    import csr_isa_pkg::*;
    import csr_port_pkg::*;

    localparam int timeout_cycles = 50;

    logic clk = 1'b0;
    logic rst;
    logic new_request;
    csr_request_t request;
    logic ready;
    logic done;
    logic [`CSR_XLEN-1:0] rd;
    logic ack;
    trap_event_t trap;
    m_interrupt_t irq;
    csr_event_t events;
    logic interrupt_pending;
    logic [`CSR_XLEN-1:0] exception_target_pc;
    logic [`CSR_XLEN-1:0] epc;

    int value_errors = 0;
    int protocol_errors = 0;
    int timeouts = 0;

    // Reference model state
    logic [31:0] model_mscratch;
    logic [31:0] model_mie;
    logic [31:0] model_mstatus;
    logic [31:0] model_mtvec;
    logic [63:0] model_minstret;
    logic [31:0] trapped_pc;

    always #2 clk = ~clk;

    csr_unit i_csr_unit (
        .clk                 (clk),
        .rst                 (rst),
        .new_request         (new_request),
        .request             (request),
        .ready               (ready),
        .done                (done),
        .rd                  (rd),
        .ack                 (ack),
        .trap                (trap),
        .irq                 (irq),
        .events              (events),
        .interrupt_pending   (interrupt_pending),
        .exception_target_pc (exception_target_pc),
        .epc                 (epc)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Protocol and trap rules
    always @(posedge clk) begin
        if (trap.exception_valid)
            trapped_pc <= {trap.exception_pc[31:2], 2'b00};
    end

    hold_result: assert property (@(posedge clk) disable iff (rst)
        done && !ack |=> done && $stable(rd))
    else begin
        protocol_errors++;
        $display("%0t: done or rd changed while ack was withheld", $time);
    end

    busy_while_done: assert property (@(posedge clk) disable iff (rst) done |-> !ready)
    else begin
        protocol_errors++;
        $display("%0t: ready was high while a result was waiting for ack", $time);
    end

    // Busy in the cycle after issue and the result one cycle later
    accept_timing: assert property (@(posedge clk) disable iff (rst)
        new_request && ready |=> !ready ##1 done)
    else begin
        protocol_errors++;
        $display("%0t: an accepted request did not follow the issue timing", $time);
    end

    epc_capture: assert property (@(posedge clk) disable iff (rst)
        trap.exception_valid |=> epc == trapped_pc)
    else begin
        value_errors++;
        $display("[ERROR] %0t epc expected %h actual %h", $time, trapped_pc, epc);
    end

    ////////////////////////////////////////////////////////////////////////////
    // Model rules
    function automatic logic [31:0] modify(input csr_op_e op, input logic [31:0] old,
                                           input logic [31:0] data);
        case (op)
            op_rs:   return old | data;
            op_rc:   return old & ~data;
            default: return data;
        endcase
    endfunction

    // Only mie and mpie are writable and mpp reads as machine
    function automatic logic [31:0] status_write(input logic [31:0] value);
        return 32'h0000_1800 | (value & 32'h0000_0088);
    endfunction

    function automatic logic [31:0] status_trap_entry(input logic [31:0] status);
        return 32'h0000_1800 | (status[3] ? 32'h0000_0080 : 32'h0);
    endfunction

    function automatic logic [31:0] status_mret(input logic [31:0] status);
        return 32'h0000_1880 | (status[7] ? 32'h0000_0008 : 32'h0);
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        assert (actual === expected)
        else begin
            value_errors++;
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    task automatic access(input logic [11:0] addr, input csr_op_e op, input logic [31:0] data,
                          input int ack_delay, output logic [31:0] value);
        int waited;
        csr_request_t req;
        waited = 0;
        @(negedge clk);
        while (!ready && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (!ready) begin
            timeouts++;
            $display("Timed out waiting for ready before a request to CSR %h", addr);
        end
        req.addr = csr_addr_e'(addr);
        req.op = op;
        req.data = data;
        @(posedge clk);
        new_request <= 1'b1;
        request <= req;
        @(posedge clk);
        new_request <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!done && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            timeouts++;
            $display("Timed out waiting for done on a request to CSR %h", addr);
        end
        value = rd;
        // Back-pressure before the result is taken
        repeat (ack_delay) @(posedge clk);
        @(posedge clk);
        ack <= 1'b1;
        @(posedge clk);
        ack <= 1'b0;
    endtask

    task automatic read_csr(input logic [11:0] addr, output logic [31:0] value);
        access(addr, op_rs, 32'h0, $urandom % 4, value);
    endtask

    task automatic write_csr(input logic [11:0] addr, input csr_op_e op, input logic [31:0] data);
        logic [31:0] old_value;
        access(addr, op, data, $urandom % 4, old_value);
    endtask

    task automatic pulse_trap(input trap_event_t pulse);
        @(posedge clk);
        trap <= pulse;
        @(posedge clk);
        trap <= '0;
        @(negedge clk);
    endtask

    task automatic wait_for_pending();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!interrupt_pending && waited < timeout_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (!interrupt_pending) begin
            timeouts++;
            $display("Timed out waiting for interrupt_pending after the timer line rose");
        end
    endtask

    initial begin
        logic [31:0] value;
        logic [31:0] cycles;
        logic [31:0] data;
        logic [31:0] pc;
        logic [1:0] retired;
        trap_event_t pulse;
        csr_op_e ops [3];

        void'($urandom(32));
        rst = 1'b1;
        new_request = 1'b0;
        request = '0;
        ack = 1'b0;
        trap = '0;
        irq = '0;
        events = '0;
        model_mstatus = 32'h0000_1800;
        model_mie = 32'h0;
        model_mtvec = `CSR_RESET_MTVEC;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare("ready", 32'd1, 32'(ready));
        compare("done", 32'd0, 32'(done));
        compare("interrupt_pending", 32'd0, 32'(interrupt_pending));

        // Fixed values after reset
        read_csr(csr_mstatus, value);
        compare("mstatus", model_mstatus, value);
        read_csr(csr_mtvec, value);
        compare("mtvec", model_mtvec, value);
        read_csr(csr_misa, value);
        compare("misa", 32'h4000_1100, value);
        read_csr(csr_mhartid, value);
        compare("mhartid", 32'(`CSR_HART_ID), value);
        read_csr(csr_mcause, value);
        compare("mcause", 32'h0, value);
        read_csr(12'h7C0, value);
        compare("unknown CSR", 32'h0, value);

        // Read-modify-write on mscratch
        ops = '{op_rw, op_rs, op_rc};
        model_mscratch = $urandom;
        write_csr(csr_mscratch, op_rw, model_mscratch);
        for (int i = 0; i < 6; i++) begin
            data = $urandom;
            access(csr_mscratch, ops[i % 3], data, (i == 0) ? 3 : int'($urandom % 4), value);
            compare("rd", model_mscratch, value);
            model_mscratch = modify(ops[i % 3], model_mscratch, data);
            read_csr(csr_mscratch, value);
            compare("mscratch", model_mscratch, value);
        end

        ////////////////////////////////////////////////////////////////////////////
        // Counters
        @(posedge clk);
        events.cycle_active <= 1'b1;
        cycles = 32'd0;
        // One count for every edge that sees the active level
        repeat (4) begin
            @(posedge clk);
            cycles = cycles + 32'd1;
        end
        events.cycle_active <= 1'b0;
        read_csr(csr_mcycle, value);
        compare("mcycle", cycles, value);
        read_csr(csr_mcycle, value);
        compare("mcycle", cycles, value);
        read_csr(csr_mcycleh, value);
        compare("mcycleh", 32'h0, value);

        model_minstret[31:0] = $urandom;
        model_minstret[63:32] = $urandom;
        write_csr(csr_minstret, op_rw, model_minstret[31:0]);
        write_csr(csr_minstreth, op_rw, model_minstret[63:32]);
        for (int i = 0; i < 6; i++) begin
            retired = 2'($urandom % 4);
            @(posedge clk);
            events.retire_count <= retired;
            model_minstret = model_minstret + 64'(retired);
        end
        @(posedge clk);
        events.retire_count <= '0;
        read_csr(csr_instret, value);
        compare("instret", model_minstret[31:0], value);
        read_csr(csr_instreth, value);
        compare("instreth", model_minstret[63:32], value);

        // Read-only alias ignores the write
        write_csr(csr_cycle, op_rw, $urandom);
        read_csr(csr_mcycle, value);
        compare("mcycle", cycles, value);
        read_csr(csr_cycleh, value);
        compare("cycleh", 32'h0, value);

        ////////////////////////////////////////////////////////////////////////////
        // Timer interrupt, trap entry and mret
        data = $urandom | 32'h0000_0080;
        write_csr(csr_mie, op_rw, data);
        model_mie = data & 32'h0000_0888;
        read_csr(csr_mie, value);
        compare("mie", model_mie, value);
        write_csr(csr_mstatus, op_rs, 32'h0000_0008);
        model_mstatus = status_write(modify(op_rs, model_mstatus, 32'h0000_0008));
        read_csr(csr_mstatus, value);
        compare("mstatus", model_mstatus, value);
        compare("interrupt_pending", 32'd0, 32'(interrupt_pending));

        @(posedge clk);
        irq.timer <= 1'b1;
        wait_for_pending();
        compare("interrupt_pending", 32'd1, 32'(interrupt_pending));
        pulse = '0;
        pulse.interrupt_taken = 1'b1;
        pulse_trap(pulse);
        model_mstatus = status_trap_entry(model_mstatus);
        compare("interrupt_pending", 32'd0, 32'(interrupt_pending));
        @(posedge clk);
        irq.timer <= 1'b0;
        read_csr(csr_mcause, value);
        compare("mcause", 32'h8000_0007, value);
        read_csr(csr_mstatus, value);
        compare("mstatus", model_mstatus, value);

        pulse = '0;
        pulse.mret = 1'b1;
        pulse_trap(pulse);
        model_mstatus = status_mret(model_mstatus);
        read_csr(csr_mstatus, value);
        compare("mstatus", model_mstatus, value);

        ////////////////////////////////////////////////////////////////////////////
        // Exception entry and mcause legality
        data = $urandom;
        write_csr(csr_mtvec, op_rw, data);
        model_mtvec = data & ~32'h3;
        read_csr(csr_mtvec, value);
        compare("mtvec", model_mtvec, value);
        compare("exception_target_pc", model_mtvec, exception_target_pc);

        pc = $urandom;
        pulse = '0;
        pulse.exception_valid = 1'b1;
        pulse.exception_code = exc_illegal_inst;
        pulse.exception_pc = pc;
        pulse_trap(pulse);
        model_mstatus = status_trap_entry(model_mstatus);
        compare("epc", pc & ~32'h3, epc);
        read_csr(csr_mepc, value);
        compare("mepc", pc & ~32'h3, value);
        read_csr(csr_mcause, value);
        compare("mcause", 32'h0000_0002, value);
        read_csr(csr_mstatus, value);
        compare("mstatus", model_mstatus, value);

        // Codes 10 and interrupt 5 are not implemented
        write_csr(csr_mcause, op_rw, 32'h0000_000A);
        read_csr(csr_mcause, value);
        compare("mcause", 32'h0000_0002, value);
        write_csr(csr_mcause, op_rw, 32'h8000_0005);
        read_csr(csr_mcause, value);
        compare("mcause", 32'h0000_0002, value);

        $display("Errors: %0d value, %0d protocol, %0d timeouts",
                 value_errors, protocol_errors, timeouts);
        if (value_errors == 0 && protocol_errors == 0 && timeouts == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== source/csr_unit.sv ====
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_unit (
    input logic clk,
    input logic rst,
    input logic new_request,
    input csr_port_pkg::csr_request_t request,
    output logic ready,
    output logic done,
    output logic [`CSR_XLEN-1:0] rd,
    input logic ack,
    input csr_port_pkg::trap_event_t trap,
    input csr_port_pkg::m_interrupt_t irq,
    input csr_port_pkg::csr_event_t events,
    output logic interrupt_pending,
    output logic [`CSR_XLEN-1:0] exception_target_pc,
    output logic [`CSR_XLEN-1:0] epc
);
    import csr_port_pkg::*;

    csr_request_t latched;
    csr_write_t csr_write;
    logic commit;
    logic [`CSR_XLEN-1:0] selected_value;
    logic [`CSR_NUM_COUNTERS-1:0][`CSR_COUNTER_W-1:0] counts;
    logic [`CSR_NUM_COUNTERS-1:0][`CSR_RETIRE_W-1:0] increments;
    logic [`CSR_XLEN-1:0] mstatus;
    logic [`CSR_XLEN-1:0] mie;
    logic [`CSR_XLEN-1:0] mip;
    logic [`CSR_XLEN-1:0] mtvec;
    logic [`CSR_XLEN-1:0] mscratch;
    logic [`CSR_XLEN-1:0] mepc;
    logic [`CSR_XLEN-1:0] mcause;

    csr_request_ctrl i_request_ctrl (
        .clk            (clk),
        .rst            (rst),
        .new_request    (new_request),
        .request        (request),
        .ack            (ack),
        .selected_value (selected_value),
        .ready          (ready),
        .done           (done),
        .commit         (commit),
        .latched        (latched),
        .csr_write      (csr_write)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Counters
    // mcycle steps only while the core is active
    assign increments[0] = `CSR_RETIRE_W'(events.cycle_active);
    assign increments[1] = events.retire_count;

    generate
        for (genvar i = 0; i < `CSR_NUM_COUNTERS; i++) begin : gen_counters
            csr_counter #(
                .COUNTER_INDEX (i)
            ) i_counter (
                .clk       (clk),
                .rst       (rst),
                .csr_write (csr_write),
                .increment (increments[i]),
                .count     (counts[i])
            );
        end
    endgenerate

    csr_trap_regs i_trap_regs (
        .clk                 (clk),
        .rst                 (rst),
        .csr_write           (csr_write),
        .trap                (trap),
        .irq                 (irq),
        .mstatus             (mstatus),
        .mie                 (mie),
        .mip                 (mip),
        .mtvec               (mtvec),
        .mscratch            (mscratch),
        .mepc                (mepc),
        .mcause              (mcause),
        .exception_target_pc (exception_target_pc),
        .epc                 (epc),
        .interrupt_pending   (interrupt_pending)
    );

    csr_read_mux i_read_mux (
        .clk            (clk),
        .commit         (commit),
        .addr           (latched.addr),
        .counts         (counts),
        .mstatus        (mstatus),
        .mie            (mie),
        .mip            (mip),
        .mtvec          (mtvec),
        .mscratch       (mscratch),
        .mepc           (mepc),
        .mcause         (mcause),
        .rd             (rd),
        .selected_value (selected_value)
    );

endmodule

// ==== source/csr_read_mux.sv ====
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_read_mux (
    input logic clk,
    input logic commit,
    input csr_isa_pkg::csr_addr_e addr,
    input logic [`CSR_NUM_COUNTERS-1:0][`CSR_COUNTER_W-1:0] counts,
    input logic [`CSR_XLEN-1:0] mstatus,
    input logic [`CSR_XLEN-1:0] mie,
    input logic [`CSR_XLEN-1:0] mip,
    input logic [`CSR_XLEN-1:0] mtvec,
    input logic [`CSR_XLEN-1:0] mscratch,
    input logic [`CSR_XLEN-1:0] mepc,
    input logic [`CSR_XLEN-1:0] mcause,
    output logic [`CSR_XLEN-1:0] rd,
    output logic [`CSR_XLEN-1:0] selected_value
);
    import csr_isa_pkg::*;

    // RV32 with the I and M extensions
    localparam logic [25:0] extensions = (26'd1 << 8) | (26'd1 << 12);
    localparam logic [`CSR_XLEN-1:0] misa = {2'b01, 4'b0000, extensions};
    localparam logic [`CSR_XLEN-1:0] mhartid = `CSR_XLEN'(`CSR_HART_ID);

    always_comb begin
        case (addr)
            csr_misa:     selected_value = misa;
            csr_mhartid:  selected_value = mhartid;
            csr_mstatus:  selected_value = mstatus;
            csr_mie:      selected_value = mie;
            csr_mtvec:    selected_value = mtvec;
            csr_mscratch: selected_value = mscratch;
            csr_mepc:     selected_value = mepc;
            csr_mcause:   selected_value = mcause;
            csr_mip:      selected_value = mip;
            default:      selected_value = '0;
        endcase

        // Machine and user counter views
        for (int i = 0; i < `CSR_NUM_COUNTERS; i++) begin
            if (addr == counter_addr_table[i].low || addr == counter_addr_table[i].user_low)
                selected_value = counts[i][`CSR_XLEN-1:0];
            if (addr == counter_addr_table[i].high || addr == counter_addr_table[i].user_high)
                selected_value = counts[i][`CSR_COUNTER_W-1:`CSR_XLEN];
        end
    end

    // Value before any write of this request
    always_ff @(posedge clk) begin
        if (commit)
            rd <= selected_value;
    end

endmodule

// ==== source/csr_trap_regs.sv ====
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_trap_regs (
    input logic clk,
    input logic rst,
    input csr_port_pkg::csr_write_t csr_write,
    input csr_port_pkg::trap_event_t trap,
    input csr_port_pkg::m_interrupt_t irq,
    output logic [`CSR_XLEN-1:0] mstatus,
    output logic [`CSR_XLEN-1:0] mie,
    output logic [`CSR_XLEN-1:0] mip,
    output logic [`CSR_XLEN-1:0] mtvec,
    output logic [`CSR_XLEN-1:0] mscratch,
    output logic [`CSR_XLEN-1:0] mepc,
    output logic [`CSR_XLEN-1:0] mcause,
    output logic [`CSR_XLEN-1:0] exception_target_pc,
    output logic [`CSR_XLEN-1:0] epc,
    output logic interrupt_pending
);
    import csr_isa_pkg::*;

    // Only the machine level interrupt bits exist
    localparam mie_t irq_mask = '{msie: 1'b1, mtie: 1'b1, meie: 1'b1, default: '0};

    mstatus_t mstatus_r;
    mstatus_t mstatus_next;
    mstatus_t status_wdata;
    mie_t mie_r;
    mip_t mip_r;
    mip_t active;
    mcause_t mcause_r;
    logic [`CSR_XLEN-1:0] mtvec_r;
    logic [`CSR_XLEN-1:0] mepc_r;
    logic [`CSR_XLEN-1:0] mscratch_r;
    cause_code_e pending_cause;
    cause_code_e interrupt_cause_r;
    logic trap_entry;
    logic mcause_legal;
    logic wr_mstatus;
    logic wr_mie;
    logic wr_mtvec;
    logic wr_mscratch;
    logic wr_mepc;
    logic wr_mcause;

    assign wr_mstatus = csr_write.valid && (csr_write.addr == csr_mstatus);
    assign wr_mie = csr_write.valid && (csr_write.addr == csr_mie);
    assign wr_mtvec = csr_write.valid && (csr_write.addr == csr_mtvec);
    assign wr_mscratch = csr_write.valid && (csr_write.addr == csr_mscratch);
    assign wr_mepc = csr_write.valid && (csr_write.addr == csr_mepc);
    assign wr_mcause = csr_write.valid && (csr_write.addr == csr_mcause);

    assign trap_entry = trap.exception_valid | trap.interrupt_taken;
    assign status_wdata = csr_write.value;

    ////////////////////////////////////////////////////////////////////////////
    // mstatus
    always_comb begin
        mstatus_next = mstatus_r;
        if (wr_mstatus) begin
            mstatus_next.mie = status_wdata.mie;
            mstatus_next.mpie = status_wdata.mpie;
        end else if (trap_entry) begin
            mstatus_next.mpie = mstatus_r.mie;
            mstatus_next.mie = 1'b0;
        end else if (trap.mret) begin
            mstatus_next.mie = mstatus_r.mpie;
            mstatus_next.mpie = 1'b1;
        end
    end

    // mpp stays at machine
    always_ff @(posedge clk) begin
        if (rst)
            mstatus_r <= '{mpp: 2'b11, default: '0};
        else
            mstatus_r <= mstatus_next;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Interrupt enable and pending
    always_ff @(posedge clk) begin
        if (rst)
            mie_r <= '0;
        else if (wr_mie)
            mie_r <= csr_write.value & irq_mask;
    end

    // External lines are the only source of mip
    always_ff @(posedge clk) begin
        if (rst)
            mip_r <= '0;
        else
            mip_r <= '{msip: irq.software, mtip: irq.timer, meip: irq.external, default: '0};
    end

    assign active = mip_r & mie_r;
    assign interrupt_pending = mstatus_r.mie & (|active);

    // External over timer over software
    always_comb begin
        pending_cause = int_m_software;
        if (active.meip)
            pending_cause = int_m_external;
        else if (active.mtip)
            pending_cause = int_m_timer;
    end

    always_ff @(posedge clk) begin
        if (interrupt_pending)
            interrupt_cause_r <= pending_cause;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Trap vector, scratch and exception pc
    always_ff @(posedge clk) begin
        if (rst)
            mtvec_r <= `CSR_RESET_MTVEC;
        else if (wr_mtvec)
            mtvec_r <= {csr_write.value[`CSR_XLEN-1:2], 2'b00};
    end

    always_ff @(posedge clk) begin
        if (wr_mscratch)
            mscratch_r <= csr_write.value;
    end

    always_ff @(posedge clk) begin
        if (wr_mepc)
            mepc_r <= {csr_write.value[`CSR_XLEN-1:2], 2'b00};
        else if (trap_entry)
            mepc_r <= {trap.exception_pc[`CSR_XLEN-1:2], 2'b00};
    end

    ////////////////////////////////////////////////////////////////////////////
    // mcause
    // Codes are sparse so a write must name an implemented cause
    always_comb begin
        if (csr_write.value[`CSR_XLEN-1])
            mcause_legal = csr_write.value[`CSR_ECODE_W-1:0] inside
                {int_m_software, int_m_timer, int_m_external};
        else
            mcause_legal = csr_write.value[`CSR_ECODE_W-1:0] inside
                {exc_inst_misaligned, exc_illegal_inst, exc_breakpoint,
                 exc_load_misaligned, exc_store_misaligned, exc_ecall_m};
    end

    always_ff @(posedge clk) begin
        if (rst)
            mcause_r <= '0;
        else if (wr_mcause && mcause_legal)
            mcause_r <= '{is_interrupt: csr_write.value[`CSR_XLEN-1], zeroes: '0,
                          code: csr_write.value[`CSR_ECODE_W-1:0]};
        else if (trap.interrupt_taken)
            mcause_r <= '{is_interrupt: 1'b1, zeroes: '0, code: interrupt_cause_r};
        else if (trap.exception_valid)
            mcause_r <= '{is_interrupt: 1'b0, zeroes: '0, code: trap.exception_code};
    end

    assign mstatus = mstatus_r;
    assign mie = mie_r;
    assign mip = mip_r;
    assign mtvec = mtvec_r;
    assign mscratch = mscratch_r;
    assign mepc = mepc_r;
    assign mcause = mcause_r;
    assign exception_target_pc = mtvec_r;
    assign epc = mepc_r;

endmodule

// ==== source/csr_counter.sv ====
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_counter #(
    parameter int COUNTER_INDEX = 0
) (
    input logic clk,
    input logic rst,
    input csr_port_pkg::csr_write_t csr_write,
    input logic [`CSR_RETIRE_W-1:0] increment,
    output logic [`CSR_COUNTER_W-1:0] count
);
    import csr_isa_pkg::*;

    localparam csr_addr_e low_addr = counter_addr_table[COUNTER_INDEX].low;
    localparam csr_addr_e high_addr = counter_addr_table[COUNTER_INDEX].high;

    logic write_low;
    logic write_high;
    logic [`CSR_COUNTER_W-1:0] count_next;

    assign write_low = csr_write.valid && (csr_write.addr == low_addr);
    assign write_high = csr_write.valid && (csr_write.addr == high_addr);

    // A write to either half replaces this cycle's increment
    always_comb begin
        count_next = count + `CSR_COUNTER_W'(increment);
        if (write_low)
            count_next = {count[`CSR_COUNTER_W-1:`CSR_XLEN], csr_write.value};
        else if (write_high)
            count_next = {csr_write.value[`CSR_COUNTER_W-`CSR_XLEN-1:0], count[`CSR_XLEN-1:0]};
    end

    always_ff @(posedge clk) begin
        if (rst)
            count <= '0;
        else
            count <= count_next;
    end

endmodule

// ==== source/csr_request_ctrl.sv ====
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_request_ctrl (
    input logic clk,
    input logic rst,
    input logic new_request,
    input csr_port_pkg::csr_request_t request,
    input logic ack,
    input logic [`CSR_XLEN-1:0] selected_value,
    output logic ready,
    output logic done,
    output logic commit,
    output csr_port_pkg::csr_request_t latched,
    output csr_port_pkg::csr_write_t csr_write
);
    import csr_isa_pkg::*;

    logic busy;
    logic accept;
    logic commit_in_progress;
    logic writable;
    logic [`CSR_XLEN-1:0] updated_value;
    logic write_valid;
    csr_addr_e write_addr;
    logic [`CSR_XLEN-1:0] write_value;

    ////////////////////////////////////////////////////////////////////////////
    // Issue and commit sequencing
    assign ready = ~busy;
    assign accept = new_request & ready;

    always_ff @(posedge clk) begin
        if (rst)
            busy <= 1'b0;
        else
            busy <= (busy & ~ack) | accept;
    end

    always_ff @(posedge clk) begin
        if (accept)
            latched <= request;
    end

    // One commit per accepted request, on the cycle after issue
    assign commit = busy & ~commit_in_progress;

    always_ff @(posedge clk) begin
        if (rst)
            commit_in_progress <= 1'b0;
        else
            commit_in_progress <= (commit_in_progress & ~accept) | commit;
    end

    // Held until the consumer takes the result
    always_ff @(posedge clk) begin
        if (rst)
            done <= 1'b0;
        else
            done <= (done & ~ack) | commit;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read-modify-write
    always_comb begin
        case (latched.op)
            op_rs:   updated_value = selected_value | latched.data;
            op_rc:   updated_value = selected_value & ~latched.data;
            default: updated_value = latched.data;
        endcase
    end

    // Top address bits of 2'b11 mark a read-only CSR
    assign writable = (latched.addr[11:10] != 2'b11);

    always_ff @(posedge clk) begin
        if (rst)
            write_valid <= 1'b0;
        else
            write_valid <= commit & writable;
    end

    always_ff @(posedge clk) begin
        if (commit) begin
            write_addr <= latched.addr;
            write_value <= updated_value;
        end
    end

    assign csr_write = '{valid: write_valid, addr: write_addr, value: write_value};

endmodule

// ==== source/csr_port_pkg.sv ====
`include "csr_consts.svh"

package csr_port_pkg;

    // Request from the issue stage
    typedef struct packed {
        csr_isa_pkg::csr_addr_e addr;
        csr_isa_pkg::csr_op_e   op;
        logic [`CSR_XLEN-1:0]   data;
    } csr_request_t;

    // Registered write to the CSR storage blocks
    typedef struct packed {
        logic                   valid;
        csr_isa_pkg::csr_addr_e addr;
        logic [`CSR_XLEN-1:0]   value;
    } csr_write_t;

    // Single cycle pulses from the core
    typedef struct packed {
        logic                     exception_valid;
        csr_isa_pkg::cause_code_e exception_code;
        logic [`CSR_XLEN-1:0]     exception_pc;
        logic                     interrupt_taken;
        logic                     mret;
    } trap_event_t;

    typedef struct packed {
        logic software;
        logic timer;
        logic external;
    } m_interrupt_t;

    // Levels sampled every cycle
    typedef struct packed {
        logic                     cycle_active;
        logic [`CSR_RETIRE_W-1:0] retire_count;
    } csr_event_t;

endpackage

// ==== source/csr_isa_pkg.sv ====
`include "csr_consts.svh"

package csr_isa_pkg;

    // Machine mode CSRs and the user read-only counter aliases
    typedef enum logic [11:0] {
        csr_mstatus   = 12'h300,
        csr_misa      = 12'h301,
        csr_mie       = 12'h304,
        csr_mtvec     = 12'h305,
        csr_mscratch  = 12'h340,
        csr_mepc      = 12'h341,
        csr_mcause    = 12'h342,
        csr_mip       = 12'h344,
        csr_mcycle    = 12'hB00,
        csr_minstret  = 12'hB02,
        csr_mcycleh   = 12'hB80,
        csr_minstreth = 12'hB82,
        csr_cycle     = 12'hC00,
        csr_instret   = 12'hC02,
        csr_cycleh    = 12'hC80,
        csr_instreth  = 12'hC82,
        csr_mhartid   = 12'hF14
    } csr_addr_e;

    // Same encoding as funct3[1:0] of the CSR instructions
    typedef enum logic [1:0] {
        op_rw = 2'b01,
        op_rs = 2'b10,
        op_rc = 2'b11
    } csr_op_e;

    typedef enum logic [`CSR_ECODE_W-1:0] {
        exc_inst_misaligned  = 5'd0,
        exc_illegal_inst     = 5'd2,
        exc_breakpoint       = 5'd3,
        exc_load_misaligned  = 5'd4,
        exc_store_misaligned = 5'd6,
        int_m_timer          = 5'd7,
        exc_ecall_m          = 5'd11
    } cause_code_e;

    // Interrupt codes that share their value with an exception code
    localparam cause_code_e int_m_software = exc_breakpoint;
    localparam cause_code_e int_m_external = exc_ecall_m;

    typedef struct packed {
        logic [18:0] reserved_31_13;
        logic [1:0]  mpp;
        logic [2:0]  reserved_10_8;
        logic        mpie;
        logic [2:0]  reserved_6_4;
        logic        mie;
        logic [2:0]  reserved_2_0;
    } mstatus_t;

    typedef struct packed {
        logic [19:0] reserved_31_12;
        logic        meie;
        logic [2:0]  reserved_10_8;
        logic        mtie;
        logic [2:0]  reserved_6_4;
        logic        msie;
        logic [2:0]  reserved_2_0;
    } mie_t;

    typedef struct packed {
        logic [19:0] reserved_31_12;
        logic        meip;
        logic [2:0]  reserved_10_8;
        logic        mtip;
        logic [2:0]  reserved_6_4;
        logic        msip;
        logic [2:0]  reserved_2_0;
    } mip_t;

    typedef struct packed {
        logic                                is_interrupt;
        logic [`CSR_XLEN-`CSR_ECODE_W-2:0]   zeroes;
        logic [`CSR_ECODE_W-1:0]             code;
    } mcause_t;

    ////////////////////////////////////////////////////////////////////////////
    // Counter addresses by counter index
    typedef struct packed {
        csr_addr_e low;
        csr_addr_e high;
        csr_addr_e user_low;
        csr_addr_e user_high;
    } counter_addr_t;

    localparam counter_addr_t counter_addr_table [`CSR_NUM_COUNTERS] = '{
        '{csr_mcycle, csr_mcycleh, csr_cycle, csr_cycleh},
        '{csr_minstret, csr_minstreth, csr_instret, csr_instreth}
    };

endpackage

// ==== source/csr_consts.svh ====
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// Datapath widths
`define CSR_XLEN 32
`define CSR_COUNTER_W 64

// Width of the code field in mcause
`define CSR_ECODE_W 5

// Up to three instructions retire per cycle
`define CSR_RETIRE_W 2

// Index 0 counts cycles and index 1 counts retired instructions
`define CSR_NUM_COUNTERS 2

// Trap vector after reset
`define CSR_RESET_MTVEC 32'h0000_0100

// Single hart system
`define CSR_HART_ID 0

`endif
